// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_backend
FILELIST  ?= project.f
FLAGS     ?= --assert --timing
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Exit status of the simulator is the test result
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_checks.svh ====
// Register stability while the cache stalls
stall_hold: assert property (@(posedge CLK) disable iff (!rst_n)
    !data_ready |=> ($stable(wb_valid) && $stable(wb_rd) && $stable(written_back)
                     && $stable(return_addr)))
    else fail_run("Pipeline outputs changed while data_ready was low");

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else
    begin
        $display("ERR %s expected %h actual %h", name, exp, act);
        fail_run("Value mismatch");
    end
endtask

task automatic check_reset_state();
    check_value("wb_valid", 32'(1'b0), 32'(wb_valid));
    check_value("written_back", 32'h0, written_back);
    check_value("return_addr", 32'h0, return_addr);
    check_value("mem_ctrl", 32'(CTRL_IDLE), 32'(mem_ctrl));
endtask

task automatic check_forward(input string name, input logic [FWD_SEL_W-1:0] sel,
                             input logic [XLEN-1:0] reg_val, input logic [XLEN-1:0] act);
    case (sel)
        FWD_REG:  check_value(name, reg_val, act);
        FWD_ZERO: check_value(name, 32'h0, act);
        FWD_EX:   check_value(name, ex_result, act);
        FWD_MEM1: if (res_ok[0]) check_value(name, m_res[0], act);
        FWD_MEM2: if (res_ok[1]) check_value(name, m_res[1], act);
        FWD_MEM3: if (res_ok[2]) check_value(name, m_res[2], act);
        FWD_WB:   if (res_ok[3]) check_value(name, cur_wb_data, act);
        default:  if (written_ok) check_value(name, exp_written, act);
    endcase
endtask

task automatic check_outputs();
    logic [1:0]      off;
    logic [3:0]      be;
    logic [1:0]      ctrl;
    issued_t         ent;
    off  = ex_result[1:0];
    ctrl = !ex_valid ? CTRL_IDLE : (ex_kind == KIND_LOAD) ? CTRL_READ
         : (ex_kind == KIND_STORE) ? CTRL_WRITE : CTRL_IDLE;
    be = 4'b0000;
    if (ctrl == CTRL_WRITE)
    begin
        if (ex_size == SZ_BYTE)
            be = 4'b0001 << off;
        else if (ex_size == SZ_HALF && off != 2'd3)
            be = 4'b0011 << off;
        else if (ex_size == SZ_WORD)
            be = 4'b1111;
    end
    check_value("mem_ctrl", 32'(ctrl), 32'(mem_ctrl));
    check_value("mem_addr", {ex_result[31:2], 2'b00}, mem_addr);
    check_value("mem_byte_en", 32'(be), 32'(mem_byte_en));
    check_value("mem_wdata", ex_store_data << (8 * off), mem_wdata);

    cur_wb_data = (m_kind[3] == KIND_LOAD) ? format_load(m_size[3], m_res[3][1:0], load_data)
                                           : m_res[3];
    check_value("wb_valid", 32'(m_kind[3] != KIND_IDLE), 32'(wb_valid));
    if (res_ok[3])
        check_value("wb_data", cur_wb_data, wb_data);
    if (written_ok)
        check_value("written_back", exp_written, written_back);
    check_value("return_addr", exp_ra, return_addr);

    if (wb_valid && moved)
    begin
        if (issued_q.size() == 0)
            fail_run("Instruction arrived at writeback that was never issued");
        ent = issued_q.pop_front();
        check_value("wb_rd", 32'(ent.rd), 32'(wb_rd));
        if (m_kind[3] != KIND_LOAD)
            check_value("wb_data", ent.result, wb_data);
        check_value("ready_edges", 32'(ent.issue + 4), 32'(ready_edges));
    end
    if (issued_q.size() != 0 && ready_edges - issued_q[0].issue > AGE_LIMIT)
        fail_run("Timeout waiting for an instruction to reach writeback");

    check_forward("rs1_fwd", rs1_sel, rs1_reg, rs1_fwd);
    check_forward("rs2_fwd", rs2_sel, rs2_reg, rs2_fwd);
endtask

// ==== bench/tb_mem_backend.sv ====
`timescale 1ns/1ns

module tb_mem_backend
    import mem_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int RESET_LEN   = 8;
    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 40;
    localparam int AGE_LIMIT   = 200;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        int                    issue;
    } issued_t;

    logic                  CLK;
    logic                  rst_n;
    logic                  ex_valid;
    logic [KIND_W-1:0]     ex_kind;
    logic [SIZE_W-1:0]     ex_size;
    logic [REG_ADDR_W-1:0] ex_rd;
    logic [XLEN-1:0]       ex_result;
    logic [XLEN-1:0]       ex_store_data;
    logic                  data_ready;
    logic [XLEN-1:0]       load_data;
    logic [FWD_SEL_W-1:0]  rs1_sel;
    logic [FWD_SEL_W-1:0]  rs2_sel;
    logic [XLEN-1:0]       rs1_reg;
    logic [XLEN-1:0]       rs2_reg;
    logic [CTRL_W-1:0]     mem_ctrl;
    logic [XLEN-1:0]       mem_addr;
    logic [BYTE_LANES-1:0] mem_byte_en;
    logic [XLEN-1:0]       mem_wdata;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic [XLEN-1:0]       written_back;
    logic [XLEN-1:0]       return_addr;
    logic [XLEN-1:0]       rs1_fwd;
    logic [XLEN-1:0]       rs2_fwd;

    // Reference model of the four stages
    logic [KIND_W-1:0]     m_kind [4];
    logic [SIZE_W-1:0]     m_size [4];
    logic [REG_ADDR_W-1:0] m_rd   [4];
    logic [XLEN-1:0]       m_res  [4];
    logic                  res_ok [4];
    logic [XLEN-1:0]       exp_written;
    logic                  written_ok;
    logic [XLEN-1:0]       exp_ra;
    logic [XLEN-1:0]       cur_wb_data;
    logic                  moved;
    issued_t               issued_q [$];
    int                    ready_edges;
    integer                seed;

    logic [SIZE_W-1:0] size_codes [5] = '{SZ_BYTE, SZ_HALF, SZ_WORD, SZ_UBYTE, SZ_UHALF};

    mem_backend_top i_dut (.*);

    initial
    begin
        CLK = 1'b0;
        forever #(CLK_PERIOD/2) CLK = ~CLK;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // Expected load result by size and lane
    function automatic logic [XLEN-1:0] format_load(
        input logic [SIZE_W-1:0] size,
        input logic [1:0]        off,
        input logic [XLEN-1:0]   d
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = d[{off, 3'b000} +: 8];
        h = (off == 2'd3) ? 16'h0000 : d[{off, 3'b000} +: 16];
        case (size)
            SZ_BYTE:  return {{24{b[7]}}, b};
            SZ_UBYTE: return {24'h000000, b};
            SZ_HALF:  return (off == 2'd3) ? 32'h0 : {{16{h[15]}}, h};
            SZ_UHALF: return (off == 2'd3) ? 32'h0 : {16'h0000, h};
            default:  return d;
        endcase
    endfunction

    `include "tb_checks.svh"

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic drive_inputs(input bit allow_issue);
        logic [31:0] r;
        logic [7:0]  idx;
        r = $random(seed);
        ex_valid   = allow_issue && (r[2:0] != 3'd0);
        ex_kind    = r[4:3];
        idx        = r[15:8] % 8'd5;
        ex_size    = size_codes[idx];
        ex_rd      = (r[18:16] == 3'd0) ? RA_REG : r[23:19];
        data_ready = !allow_issue || (r[26:25] != 2'd0);
        rs1_sel    = r[29:27];
        r = $random(seed);
        rs2_sel       = r[2:0];
        ex_result     = $random(seed);
        ex_store_data = $random(seed);
        load_data     = $random(seed);
        rs1_reg       = $random(seed);
        rs2_reg       = $random(seed);
    endtask

    task automatic update_model();
        issued_t ent;
        if (data_ready)
        begin
            exp_written = cur_wb_data;
            written_ok  = res_ok[3];
            if (m_kind[3] != KIND_IDLE && m_rd[3] == RA_REG)
                exp_ra = cur_wb_data;
            for (int i = 3; i > 0; i--)
            begin
                m_kind[i] = m_kind[i-1];
                m_size[i] = m_size[i-1];
                m_rd[i]   = m_rd[i-1];
                m_res[i]  = m_res[i-1];
                res_ok[i] = res_ok[i-1];
            end
            m_kind[0] = ex_valid ? ex_kind : KIND_IDLE;
            m_size[0] = ex_size;
            m_rd[0]   = ex_rd;
            m_res[0]  = ex_result;
            res_ok[0] = 1'b1;
            if (ex_valid && ex_kind != KIND_IDLE)
            begin
                ent.rd     = ex_rd;
                ent.result = ex_result;
                ent.issue  = ready_edges;
                issued_q.push_back(ent);
            end
            ready_edges++;
        end
        moved = data_ready;
    endtask

    task automatic run_cycle(input bit allow_issue);
        @(negedge CLK);
        drive_inputs(allow_issue);
        #(CLK_PERIOD/4);
        check_outputs();
        @(posedge CLK);
        update_model();
    endtask

    initial
    begin
        int waited;
        seed        = 40317;
        rst_n       = 1'b0;
        ex_valid    = 1'b0;
        ex_kind     = KIND_IDLE;
        ex_size     = SZ_WORD;
        ex_rd       = '0;
        ex_result   = '0;
        ex_store_data = '0;
        data_ready  = 1'b1;
        load_data   = '0;
        rs1_sel     = FWD_REG;
        rs2_sel     = FWD_REG;
        rs1_reg     = '0;
        rs2_reg     = '0;
        for (int i = 0; i < 4; i++)
        begin
            m_kind[i] = KIND_IDLE;
            res_ok[i] = 1'b0;
        end
        exp_written = '0;
        written_ok  = 1'b1;
        exp_ra      = '0;
        moved       = 1'b0;
        ready_edges = 0;
        repeat (RESET_LEN) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        #(CLK_PERIOD/4);
        check_reset_state();
        @(posedge CLK);
        update_model();

        for (int n = 0; n < NUM_CYCLES; n++)
            run_cycle(1'b1);

        // Drain what is still in flight
        waited = 0;
        while (issued_q.size() != 0)
        begin
            if (waited >= DRAIN_LIMIT)
                fail_run("Timeout while draining the pipeline");
            run_cycle(1'b0);
            waited++;
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+bench
rtl/mem_pkg.sv
rtl/stage_if.sv
rtl/store_lane.sv
rtl/mem_pipe.sv
rtl/writeback_unit.sv
rtl/operand_forward.sv
rtl/mem_backend_top.sv
bench/tb_mem_backend.sv

// ==== rtl/mem_backend_top.sv ====
`timescale 1ns/1ns

module mem_backend_top
    import mem_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  logic [KIND_W-1:0]     ex_kind,
    input  logic [SIZE_W-1:0]     ex_size,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic [XLEN-1:0]       ex_result,
    input  logic [XLEN-1:0]       ex_store_data,
    input  logic                  data_ready,
    input  logic [XLEN-1:0]       load_data,
    input  logic [FWD_SEL_W-1:0]  rs1_sel,
    input  logic [FWD_SEL_W-1:0]  rs2_sel,
    input  logic [XLEN-1:0]       rs1_reg,
    input  logic [XLEN-1:0]       rs2_reg,
    output logic [CTRL_W-1:0]     mem_ctrl,
    output logic [XLEN-1:0]       mem_addr,
    output logic [BYTE_LANES-1:0] mem_byte_en,
    output logic [XLEN-1:0]       mem_wdata,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic [XLEN-1:0]       written_back,
    output logic [XLEN-1:0]       return_addr,
    output logic [XLEN-1:0]       rs1_fwd,
    output logic [XLEN-1:0]       rs2_fwd
);

    stage_if stage_bus ();

    store_lane i_store_lane (
        .ex_valid      (ex_valid),
        .ex_kind       (ex_kind),
        .ex_size       (ex_size),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .mem_ctrl      (mem_ctrl),
        .mem_addr      (mem_addr),
        .mem_byte_en   (mem_byte_en),
        .mem_wdata     (mem_wdata)
    );

    mem_pipe i_mem_pipe (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .data_ready (data_ready),
        .ex_valid   (ex_valid),
        .ex_kind    (ex_kind),
        .ex_size    (ex_size),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .stage      (stage_bus.pipe)
    );

    writeback_unit i_writeback_unit (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .data_ready   (data_ready),
        .load_data    (load_data),
        .stage        (stage_bus.wb),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .written_back (written_back),
        .return_addr  (return_addr)
    );

    operand_forward i_operand_forward (
        .rs1_sel      (rs1_sel),
        .rs2_sel      (rs2_sel),
        .rs1_reg      (rs1_reg),
        .rs2_reg      (rs2_reg),
        .ex_result    (ex_result),
        .wb_data      (wb_data),
        .written_back (written_back),
        .taps         (stage_bus.fwd),
        .rs1_fwd      (rs1_fwd),
        .rs2_fwd      (rs2_fwd)
    );

endmodule

// ==== rtl/mem_pipe.sv ====
`timescale 1ns/1ns

module mem_pipe
    import mem_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  data_ready,
    input  logic                  ex_valid,
    input  logic [KIND_W-1:0]     ex_kind,
    input  logic [SIZE_W-1:0]     ex_size,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  addr_word_u            ex_result,
    stage_if.pipe                 stage
);

    // Index 0 is mem1, last index is wb
    logic [KIND_W-1:0]     kind_q   [PIPE_DEPTH];
    logic [SIZE_W-1:0]     size_q   [PIPE_DEPTH];
    logic [REG_ADDR_W-1:0] rd_q     [PIPE_DEPTH];
    addr_word_u            result_q [PIPE_DEPTH];

    logic [KIND_W-1:0]     entry_kind;

    // Bubble when nothing valid leaves execute
    assign entry_kind = ex_valid ? ex_kind : KIND_IDLE;

    //////////////////////////////////////////////////
    // Stage control
    //////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < PIPE_DEPTH; i++)
                kind_q[i] <= KIND_IDLE;
        end
        else if (data_ready)
        begin
            kind_q[0] <= entry_kind;
            for (int i = 1; i < PIPE_DEPTH; i++)
                kind_q[i] <= kind_q[i-1];
        end
    end

    //////////////////////////////////////////////////
    // Stage payload
    //////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (data_ready)
        begin
            size_q[0]   <= ex_size;
            rd_q[0]     <= ex_rd;
            result_q[0] <= ex_result;
            for (int i = 1; i < PIPE_DEPTH; i++)
            begin
                size_q[i]   <= size_q[i-1];
                rd_q[i]     <= rd_q[i-1];
                result_q[i] <= result_q[i-1];
            end
        end
    end

    // Writeback stage out
    assign stage.wb_kind   = kind_q[PIPE_DEPTH-1];
    assign stage.wb_size   = size_q[PIPE_DEPTH-1];
    assign stage.wb_rd     = rd_q[PIPE_DEPTH-1];
    assign stage.wb_result = result_q[PIPE_DEPTH-1];

    // Taps for operand forwarding
    assign stage.mem1_result = result_q[0];
    assign stage.mem2_result = result_q[1];
    assign stage.mem3_result = result_q[2];

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int BYTE_LANES = 4;
    localparam int OFFSET_W   = $clog2(BYTE_LANES);
    localparam int PIPE_DEPTH = 4;

    // Link register
    localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd1;

    //////////////////////////////////////////////////
    // Codes
    //////////////////////////////////////////////////

    localparam int KIND_W = 2;
    localparam logic [KIND_W-1:0] KIND_IDLE  = 2'd0;
    localparam logic [KIND_W-1:0] KIND_ALU   = 2'd1;
    localparam logic [KIND_W-1:0] KIND_LOAD  = 2'd2;
    localparam logic [KIND_W-1:0] KIND_STORE = 2'd3;

    // Same encoding as funct3 of loads and stores
    localparam int SIZE_W = 3;
    localparam logic [SIZE_W-1:0] SZ_BYTE  = 3'b000;
    localparam logic [SIZE_W-1:0] SZ_HALF  = 3'b001;
    localparam logic [SIZE_W-1:0] SZ_WORD  = 3'b010;
    localparam logic [SIZE_W-1:0] SZ_UBYTE = 3'b100;
    localparam logic [SIZE_W-1:0] SZ_UHALF = 3'b101;

    localparam int CTRL_W = 2;
    localparam logic [CTRL_W-1:0] CTRL_IDLE  = 2'b00;
    localparam logic [CTRL_W-1:0] CTRL_READ  = 2'b01;
    localparam logic [CTRL_W-1:0] CTRL_WRITE = 2'b10;

    localparam int FWD_SEL_W = 3;
    localparam logic [FWD_SEL_W-1:0] FWD_REG     = 3'd0;
    localparam logic [FWD_SEL_W-1:0] FWD_ZERO    = 3'd1;
    localparam logic [FWD_SEL_W-1:0] FWD_EX      = 3'd2;
    localparam logic [FWD_SEL_W-1:0] FWD_MEM1    = 3'd3;
    localparam logic [FWD_SEL_W-1:0] FWD_MEM2    = 3'd4;
    localparam logic [FWD_SEL_W-1:0] FWD_MEM3    = 3'd5;
    localparam logic [FWD_SEL_W-1:0] FWD_WB      = 3'd6;
    localparam logic [FWD_SEL_W-1:0] FWD_WRITTEN = 3'd7;

    // ALU result, seen either as a value or as a word index plus lane
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [XLEN-OFFSET_W-1:0] index;
            logic [OFFSET_W-1:0]      offset;
        } lane;
    } addr_word_u;

endpackage

// ==== rtl/operand_forward.sv ====
`timescale 1ns/1ns

module operand_forward
    import mem_pkg::*;
(
    input  logic [FWD_SEL_W-1:0] rs1_sel,
    input  logic [FWD_SEL_W-1:0] rs2_sel,
    input  logic [XLEN-1:0]      rs1_reg,
    input  logic [XLEN-1:0]      rs2_reg,
    input  logic [XLEN-1:0]      ex_result,
    input  logic [XLEN-1:0]      wb_data,
    input  logic [XLEN-1:0]      written_back,
    stage_if.fwd                 taps,
    output logic [XLEN-1:0]      rs1_fwd,
    output logic [XLEN-1:0]      rs2_fwd
);

    // Shared source mux, only the register value differs per operand
    function automatic logic [XLEN-1:0] pick_source(
        input logic [FWD_SEL_W-1:0] sel,
        input logic [XLEN-1:0]      reg_val
    );
        case (sel)
            FWD_REG:     return reg_val;
            FWD_ZERO:    return '0;
            FWD_EX:      return ex_result;
            FWD_MEM1:    return taps.mem1_result.raw;
            FWD_MEM2:    return taps.mem2_result.raw;
            FWD_MEM3:    return taps.mem3_result.raw;
            FWD_WB:      return wb_data;
            default:     return written_back;
        endcase
    endfunction

    always_comb
    begin
        rs1_fwd = pick_source(rs1_sel, rs1_reg);
        rs2_fwd = pick_source(rs2_sel, rs2_reg);
    end

endmodule

// ==== rtl/stage_if.sv ====
`timescale 1ns/1ns

interface stage_if
    import mem_pkg::*;
();

    // Writeback stage fields
    logic [KIND_W-1:0]     wb_kind;
    logic [SIZE_W-1:0]     wb_size;
    logic [REG_ADDR_W-1:0] wb_rd;
    addr_word_u            wb_result;

    // Forwarding taps
    addr_word_u            mem1_result;
    addr_word_u            mem2_result;
    addr_word_u            mem3_result;

    modport pipe (
        output wb_kind, wb_size, wb_rd, wb_result,
        output mem1_result, mem2_result, mem3_result
    );

    modport wb (
        input wb_kind, wb_size, wb_rd, wb_result
    );

    modport fwd (
        input mem1_result, mem2_result, mem3_result
    );

endinterface

// ==== rtl/store_lane.sv ====
`timescale 1ns/1ns

module store_lane
    import mem_pkg::*;
(
    input  logic                  ex_valid,
    input  logic [KIND_W-1:0]     ex_kind,
    input  logic [SIZE_W-1:0]     ex_size,
    input  addr_word_u            ex_result,
    input  logic [XLEN-1:0]       ex_store_data,
    output logic [CTRL_W-1:0]     mem_ctrl,
    output logic [XLEN-1:0]       mem_addr,
    output logic [BYTE_LANES-1:0] mem_byte_en,
    output logic [XLEN-1:0]       mem_wdata
);

    logic                is_store;
    logic [OFFSET_W-1:0] offset;

    assign is_store = ex_valid && (ex_kind == KIND_STORE);
    assign offset   = ex_result.lane.offset;

    // Cache command
    always_comb
    begin
        mem_ctrl = CTRL_IDLE;
        if (ex_valid)
        begin
            case (ex_kind)
                KIND_LOAD:  mem_ctrl = CTRL_READ;
                KIND_STORE: mem_ctrl = CTRL_WRITE;
                default:    mem_ctrl = CTRL_IDLE;
            endcase
        end
    end

    assign mem_addr = {ex_result.lane.index, {OFFSET_W{1'b0}}};

    //////////////////////////////////////////////////
    // Byte enables
    //////////////////////////////////////////////////

    always_comb
    begin
        mem_byte_en = '0;
        if (is_store)
        begin
            case (ex_size)
                SZ_BYTE:
                    mem_byte_en = BYTE_LANES'(1) << offset;
                SZ_HALF:
                begin
                    // Halfword crossing the word boundary gets no lanes
                    if (offset != '1)
                        mem_byte_en = BYTE_LANES'(3) << offset;
                end
                SZ_WORD:
                    mem_byte_en = '1;
                default:
                    mem_byte_en = '0;
            endcase
        end
    end

    // Move store data into its lane
    assign mem_wdata = ex_store_data << {offset, 3'b000};

endmodule

// ==== rtl/writeback_unit.sv ====
`timescale 1ns/1ns

module writeback_unit
    import mem_pkg::*;
(
    input  logic                  CLK,
    input  logic                  rst_n,
    input  logic                  data_ready,
    input  logic [XLEN-1:0]       load_data,
    stage_if.wb                   stage,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic [XLEN-1:0]       written_back,
    output logic [XLEN-1:0]       return_addr
);

    logic [XLEN-1:0] lane_data;
    logic [7:0]      lane_byte;
    logic [15:0]     lane_half;
    logic            half_ok;
    logic            capture_ra;

    assign wb_valid = (stage.wb_kind != KIND_IDLE);
    assign wb_rd    = stage.wb_rd;

    // Addressed byte moved down to bit 0
    assign lane_data = load_data >> {stage.wb_result.lane.offset, 3'b000};
    assign lane_byte = lane_data[7:0];
    assign lane_half = lane_data[15:0];
    assign half_ok   = (stage.wb_result.lane.offset != '1);

    //////////////////////////////////////////////////
    // Load formatting
    //////////////////////////////////////////////////

    always_comb
    begin
        wb_data = stage.wb_result.raw;
        if (stage.wb_kind == KIND_LOAD)
        begin
            case (stage.wb_size)
                SZ_BYTE:
                    wb_data = {{(XLEN-8){lane_byte[7]}}, lane_byte};
                SZ_UBYTE:
                    wb_data = {{(XLEN-8){1'b0}}, lane_byte};
                SZ_HALF:
                    wb_data = half_ok ? {{(XLEN-16){lane_half[15]}}, lane_half} : '0;
                SZ_UHALF:
                    wb_data = half_ok ? {{(XLEN-16){1'b0}}, lane_half} : '0;
                default:
                    wb_data = load_data;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Written-back and link registers
    //////////////////////////////////////////////////

    assign capture_ra = wb_valid && (stage.wb_rd == RA_REG);

    always_ff @(posedge CLK)
    begin
        if (!rst_n)
        begin
            written_back <= '0;
            return_addr  <= '0;
        end
        else if (data_ready)
        begin
            written_back <= wb_data;
            if (capture_ra)
                return_addr <= wb_data;
        end
    end

endmodule
